// File: wexDecoder_params.svh
//####################
// Widths and fixed bit positions shared by the WEX bundle decoder.
// A bundle is always two 32-bit slots, and a 16-bit op sits in the low half.
// Register number 0 doubles as the empty-slot marker.
//####################
`ifndef WEX_DECODER_PARAMS_SVH
`define WEX_DECODER_PARAMS_SVH

`define WEX_WORD_BITS	32	// One instruction slot
`define GPR_ID_BITS		6
`define UCMD_BITS		6
`define IXT_BITS		3
`define IMM_BITS		33	// Sign-extended immediate

`define ZERO_REG		6'd0	// Unused register slot

// Prefix nibble in the low halfword
`define PFX_MSB			15
`define PFX_LSB			12
`define PFX_OP32		4'hF	// Unconditional 32-bit
`define PFX_PRED		4'hE	// Predicated 32-bit

// WEX flag bits
`define DF_BIT			10
`define DW_BIT			11
`define DW_QUAL_BIT		9	// Dw needs this bit as well

`endif

// File: hdl/bundleFmtPkg.sv
//####################
// Types for the fetched bundle after prefix classification.
// Word 0 is the low 32 bits of the fetch window.
//####################
`include "wexDecoder_params.svh"

package bundleFmtPkg;

	typedef enum logic [1:0]
	{
		Op16,
		Op32,
		Op32Pred
	} wordClassE;

	typedef enum logic [1:0]
	{
		SteerScalar,	// Word 0 alone in lane A
		SteerWide,		// Word 0 WEX, lanes swapped
		SteerInvalid	// Both words claim WEX
	} steerE;

	typedef struct packed
	{
		logic [`WEX_WORD_BITS-1:0]	word1;
		logic [`WEX_WORD_BITS-1:0]	word0;
		wordClassE					wordClass1;
		wordClassE					wordClass0;
		steerE						steer;
	} classBundleT;

endpackage

// File: hdl/laneOpPkg.sv
//####################
// Types for one decoded lane.
// Command and index class values other than the named ones pass through.
//####################
`include "wexDecoder_params.svh"

package laneOpPkg;

	typedef enum logic [`UCMD_BITS-1:0]
	{
		CmdNop		= 'h00,
		CmdInvOp	= 'h3F	// Raised for a bad bundle
	} uCmdE;

	typedef enum logic [`IXT_BITS-1:0]
	{
		IxtNormal	= 'd0,
		IxtWx		= 'd1	// Op spans both lanes
	} ixtClassE;

	typedef struct packed
	{
		logic [`GPR_ID_BITS-1:0]	regN;
		logic [`GPR_ID_BITS-1:0]	regM;
		logic [`GPR_ID_BITS-1:0]	regO;
		uCmdE						uCmd;
		ixtClassE					ixt;
		logic [`IMM_BITS-1:0]		imm;
	} laneOpT;

endpackage

// File: hdl/bundleClassify.sv
//####################
// Input stage. Classifies both words and picks the lane steering.
// The bundle register loads only on inValid and has no reset.
// WEX is recognised only while srWxe is set.
//####################
`timescale 1ns/1ps
`include "wexDecoder_params.svh"

module bundleClassify import bundleFmtPkg::*;
(
	input  logic						clock,
	input  logic						reset,
	input  logic						inValid,
	input  logic [2*`WEX_WORD_BITS-1:0]	bundleWord,
	input  logic						srWxe,
	output logic						stageValid,
	output classBundleT					bundle
);

	logic [`WEX_WORD_BITS-1:0]	word0;
	logic [`WEX_WORD_BITS-1:0]	word1;
	wordClassE					wordClass0;
	wordClassE					wordClass1;
	logic						wex0;
	logic						wex1;
	classBundleT				nextBundle;

	function automatic wordClassE classify(input logic [`WEX_WORD_BITS-1:0] w);
		logic [3:0] pfx;
		pfx = w[`PFX_MSB:`PFX_LSB];
		case (pfx)
			`PFX_OP32:	return Op32;
			`PFX_PRED:	return Op32Pred;
			default:	return Op16;
		endcase
	endfunction

	// Df only counts on unpredicated ops, Dw only on predicated ones
	function automatic logic isWex(
		input logic [`WEX_WORD_BITS-1:0]	w,
		input wordClassE					c,
		input logic							wxe
	);
		logic df;
		logic dw;
		df = w[`DF_BIT] && (c == Op32);
		dw = w[`DW_BIT] && w[`DW_QUAL_BIT] && (c == Op32Pred);
		return wxe && (df || dw);
	endfunction

	assign word0 = bundleWord[`WEX_WORD_BITS-1:0];
	assign word1 = bundleWord[2*`WEX_WORD_BITS-1:`WEX_WORD_BITS];

	assign wordClass0 = classify(word0);
	assign wordClass1 = classify(word1);
	assign wex0 = isWex(word0, wordClass0, srWxe);
	assign wex1 = isWex(word1, wordClass1, srWxe);

	always_comb
	begin
		nextBundle.word0		= word0;
		nextBundle.word1		= word1;
		nextBundle.wordClass0	= wordClass0;
		nextBundle.wordClass1	= wordClass1;
		if (wex0 && wex1)
			nextBundle.steer = SteerInvalid;
		else if (wex0)
			nextBundle.steer = SteerWide;
		else
			nextBundle.steer = SteerScalar;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			stageValid <= 1'b0;
		else
			stageValid <= inValid;
	end

	always_ff @(posedge clock)
	begin
		if (inValid)
			bundle <= nextBundle;	// Held between strobes
	end

	// A strobed fetch window must be fully defined
	assert property (@(posedge clock) disable iff (reset)
		inValid |-> !$isunknown(bundleWord));

endmodule

// File: hdl/opFieldDecode.sv
//####################
// Field extraction for one classified word, purely combinational.
// 32-bit forms give 5-bit registers, 16-bit forms give 4-bit registers.
//####################
`timescale 1ns/1ps
`include "wexDecoder_params.svh"

module opFieldDecode
	import bundleFmtPkg::*;
	import laneOpPkg::*;
(
	input  logic [`WEX_WORD_BITS-1:0]	word,
	input  wordClassE					wordClass,
	output laneOpT						op
);

	logic [9:0]	imm32;	// Raw immediate of the 32-bit form
	logic [7:0]	imm16;

	assign imm32 = word[25:16];
	assign imm16 = word[7:0];

	always_comb
	begin
		if (wordClass == Op16)
		begin
			op.regN	= {2'b00, word[3:0]};
			op.regM	= {2'b00, word[7:4]};
			op.regO	= `ZERO_REG;	// No third operand
			op.uCmd	= uCmdE'(word[15:10]);
			op.ixt	= IxtNormal;
			op.imm	= {{(`IMM_BITS-8){imm16[7]}}, imm16};
		end
		else
		begin
			// Predicated and unconditional share one layout
			op.regN	= {1'b0, word[4:0]};
			op.regM	= {1'b0, word[20:16]};
			op.regO	= {1'b0, word[25:21]};
			op.uCmd	= uCmdE'(word[31:26]);
			op.ixt	= ixtClassE'(word[7:5]);
			op.imm	= {{(`IMM_BITS-10){imm32[9]}}, imm32};	// Overlaps regM and regO
		end
	end

endmodule

// File: hdl/laneSteer.sv
//####################
// Output stage. Puts the two decodes into lanes A and B and registers them.
// Lane pairing assumes even/odd register pairs, register 0 stays unpaired.
// The lanes hold their value between strobes.
//####################
`timescale 1ns/1ps
`include "wexDecoder_params.svh"

module laneSteer
	import bundleFmtPkg::*;
	import laneOpPkg::*;
(
	input  logic	clock,
	input  logic	reset,
	input  logic	stageValid,
	input  steerE	steer,
	input  laneOpT	op0,
	input  laneOpT	op1,
	output logic	outValid,
	output laneOpT	laneA,
	output laneOpT	laneB
);

	laneOpT nextA;
	laneOpT nextB;

	// Even member goes to lane A, odd member to lane B
	function automatic logic [`GPR_ID_BITS-1:0] pairReg(
		input logic [`GPR_ID_BITS-1:0]	r,
		input logic						odd
	);
		if (r == `ZERO_REG)
			return `ZERO_REG;
		return {r[`GPR_ID_BITS-1:1], odd};
	endfunction

	always_comb
	begin
		nextA = '0;
		nextB = '0;
		case (steer)
			SteerWide:
			begin
				nextA = op1;	// Second word runs in lane A
				nextB = op0;
			end
			SteerScalar:
			begin
				nextA		= op0;
				nextB.regN	= `ZERO_REG;
				nextB.regM	= op0.regN;	// Lane B reads lane A's destination
				nextB.regO	= op0.regN;
				nextB.uCmd	= CmdNop;
				nextB.ixt	= IxtNormal;
			end
			default:
				nextA.uCmd = CmdInvOp;
		endcase

		if (steer != SteerInvalid && nextA.ixt == IxtWx)
		begin
			nextB.uCmd	= nextA.uCmd;
			nextB.ixt	= nextA.ixt;
			nextB.imm	= nextA.imm;
			nextB.regN	= pairReg(nextA.regN, 1'b1);
			nextB.regM	= pairReg(nextA.regM, 1'b1);
			nextB.regO	= pairReg(nextA.regO, 1'b1);
			nextA.regN	= pairReg(nextA.regN, 1'b0);
			nextA.regM	= pairReg(nextA.regM, 1'b0);
			nextA.regO	= pairReg(nextA.regO, 1'b0);
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			outValid	<= 1'b0;
			laneA		<= '0;
			laneB		<= '0;
		end
		else
		begin
			outValid <= stageValid;
			if (stageValid)
			begin
				laneA <= nextA;
				laneB <= nextB;
			end
		end
	end

	// One output strobe per stage-1 strobe, one cycle later
	assert property (@(posedge clock) disable iff (reset)
		outValid == $past(stageValid));

	assert property (@(posedge clock) reset |=> !outValid);

endmodule

// File: hdl/wexDecoder.sv
//####################
// Two-wide WEX bundle decoder, two cycles from inValid to outValid.
// A new bundle may arrive every cycle, there is no back-pressure.
//####################
`timescale 1ns/1ps
`include "wexDecoder_params.svh"

module wexDecoder
	import bundleFmtPkg::*;
	import laneOpPkg::*;
(
	input  logic						clock,
	input  logic						reset,
	input  logic						inValid,
	input  logic [2*`WEX_WORD_BITS-1:0]	bundleWord,
	input  logic						srWxe,
	output logic						outValid,
	output laneOpT						laneA,
	output laneOpT						laneB
);

	logic			stageValid;
	classBundleT	bundle;
	laneOpT			op0;
	laneOpT			op1;

	bundleClassify classify (
		.clock		(clock),
		.reset		(reset),
		.inValid	(inValid),
		.bundleWord	(bundleWord),
		.srWxe		(srWxe),
		.stageValid	(stageValid),
		.bundle		(bundle)
	);

	opFieldDecode decWord0 (
		.word		(bundle.word0),
		.wordClass	(bundle.wordClass0),
		.op			(op0)
	);

	opFieldDecode decWord1 (
		.word		(bundle.word1),
		.wordClass	(bundle.wordClass1),
		.op			(op1)
	);

	laneSteer steerOut (
		.clock		(clock),
		.reset		(reset),
		.stageValid	(stageValid),
		.steer		(bundle.steer),
		.op0		(op0),
		.op1		(op1),
		.outValid	(outValid),
		.laneA		(laneA),
		.laneB		(laneB)
	);

endmodule

// File: bench/wexDecoderTb.sv
//####################
// Testbench for the WEX bundle decoder, stimulus from bench/wexDecoder_vectors.txt.
// Expected lanes are packed laneOpT values in hex. Run from the project root.
// Up to 64 vectors. Idle gaps between strobes come from a seeded $random.
//####################
`timescale 1ns/1ps
`include "wexDecoder_params.svh"

module wexDecoderTb
	import laneOpPkg::*;
();

	localparam int CLOCK_PERIOD	= 10;
	localparam int MAX_VECTORS	= 64;
	localparam int LINE_WORDS	= 4;	// srWxe, bundle, laneA, laneB

	logic							clock = 1'b0;
	logic							reset;
	logic							inValid;
	logic [2*`WEX_WORD_BITS-1:0]	bundleWord;
	logic							srWxe;
	logic							outValid;
	laneOpT							laneA;
	laneOpT							laneB;

	logic [63:0]	vectorMem [0:LINE_WORDS*MAX_VECTORS-1];
	laneOpT			expectA [$];
	laneOpT			expectB [$];
	int				expectNum [$];	// Vector index of each bundle in flight
	laneOpT			wantA;
	laneOpT			wantB;
	int				vectorNum;
	int				laneErrors;
	int				numVectors;
	int				passCount;
	int				failCount;
	int				protocolErrors;
	integer			seed;
	logic			vectorsLoaded;
	logic [1:0]		validPipe;	// inValid at the last two falling edges

	wexDecoder dut (
		.clock		(clock),
		.reset		(reset),
		.inValid	(inValid),
		.bundleWord	(bundleWord),
		.srWxe		(srWxe),
		.outValid	(outValid),
		.laneA		(laneA),
		.laneB		(laneB)
	);

	always #(CLOCK_PERIOD/2) clock = ~clock;

	task automatic checkField(
		input string				fieldName,
		input logic [`IMM_BITS-1:0]	got,
		input logic [`IMM_BITS-1:0]	want,
		inout int					errors
	);
		assert (got == want)
		else
		begin
			$display("[FAIL] %0t vector %0d %s is %h, expected %h",
				$time, vectorNum, fieldName, got, want);
			errors++;
		end
	endtask

	task automatic compareLane(
		input string	laneName,
		input laneOpT	got,
		input laneOpT	want,
		inout int		errors
	);
		checkField({laneName, ".regN"}, got.regN, want.regN, errors);
		checkField({laneName, ".regM"}, got.regM, want.regM, errors);
		checkField({laneName, ".regO"}, got.regO, want.regO, errors);
		checkField({laneName, ".uCmd"}, got.uCmd, want.uCmd, errors);
		checkField({laneName, ".ixt"}, got.ixt, want.ixt, errors);
		checkField({laneName, ".imm"}, got.imm, want.imm, errors);
	endtask

	always @(negedge clock)
	begin
		if (reset)
		begin
			assert (!outValid)
			else
			begin
				$display("[FAIL] %0t outValid high while reset is asserted", $time);
				protocolErrors++;
			end
		end
		// Two rising edges from sampled inValid to outValid
		assert (outValid == validPipe[1])
		else
		begin
			$display("[FAIL] %0t outValid is %b, expected %b", $time, outValid, validPipe[1]);
			protocolErrors++;
		end
		validPipe = {validPipe[0], inValid};
		if (outValid)
		begin
			if (expectA.size() == 0)
			begin
				$display("outValid came at %0t with no bundle outstanding", $time);
				protocolErrors++;
			end
			else
			begin
				wantA		= expectA.pop_front();
				wantB		= expectB.pop_front();
				vectorNum	= expectNum.pop_front();
				laneErrors	= 0;
				compareLane("laneA", laneA, wantA, laneErrors);
				compareLane("laneB", laneB, wantB, laneErrors);
				if (laneErrors == 0)
				begin
					passCount++;
					$display("Vector %0d passed", vectorNum);
				end
				else
				begin
					failCount++;
					$display("Vector %0d failed with %0d field errors", vectorNum, laneErrors);
				end
			end
		end
	end

	initial
	begin
		int addr;
		int idx;
		reset			= 1'b1;
		inValid			= 1'b0;
		bundleWord		= '0;
		srWxe			= 1'b0;
		validPipe		= '0;
		passCount		= 0;
		failCount		= 0;
		protocolErrors	= 0;
		seed			= 32'h8187_125e;
		vectorsLoaded	= 1'b0;
		for (addr = 0; addr < LINE_WORDS*MAX_VECTORS; addr++)
			vectorMem[addr] = {32'hFFFF_FFFF, addr};	// Never a legal srWxe value
		$readmemh("bench/wexDecoder_vectors.txt", vectorMem);
		numVectors = 0;
		while (numVectors < MAX_VECTORS && vectorMem[LINE_WORDS*numVectors] <= 1)
			numVectors++;
		vectorsLoaded = 1'b1;

		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;
		for (idx = 0; idx < numVectors; idx++)
		begin
			@(posedge clock);
			#1;
			srWxe		= vectorMem[LINE_WORDS*idx][0];
			bundleWord	= vectorMem[LINE_WORDS*idx+1];
			inValid		= 1'b1;
			expectA.push_back(laneOpT'(vectorMem[LINE_WORDS*idx+2][$bits(laneOpT)-1:0]));
			expectB.push_back(laneOpT'(vectorMem[LINE_WORDS*idx+3][$bits(laneOpT)-1:0]));
			expectNum.push_back(idx);
			if (($random(seed) & 3) == 0)
			begin
				@(posedge clock);	// Idle cycle
				#1;
				inValid = 1'b0;
			end
		end
		@(posedge clock);
		#1;
		inValid = 1'b0;
		while (expectA.size() != 0)
			@(posedge clock);
		repeat (3) @(posedge clock);	// No stray strobes after the last result

		$display("Vectors passed %0d, failed %0d, protocol errors %0d",
			passCount, failCount, protocolErrors);
		if (numVectors > 0 && passCount == numVectors && failCount == 0 && protocolErrors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial
	begin
		wait (vectorsLoaded === 1'b1);
		#((numVectors + 20) * CLOCK_PERIOD * 2);
		$display("Timeout: outValid never came for %0d outstanding bundles", expectA.size());
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: bench/wexDecoder_vectors.txt
// Columns: srWxe, bundle {word1, word0}, expected laneA, expected laneB
// Lanes are packed {regN, regM, regO, uCmd, ixt, imm[32:0]} in 15 hex digits
// Scalar 16-bit ops, positive and negative immediate
1 0000000000005A37 1C3016000000037 0071C0000000000
1 0000000000002C9B 2C900B1FFFFFF9B 00B2C0000000000
// Scalar 32-bit, negative immediate
1 000000004A65F00A 2854D21FFFFFE65 00A280000000000
// Df set with srWxe off
0 000000008471F41F 7D10E1000000071 01F7C0000000000
// Predicated without Dw
1 000000001402EC04 102005000000002 004100000000000
// Two-wide, F prefix with Df then E prefix with Dw
1 3085F0062022F403 18510C000000085 0C2048000000022
1 00003456C3C1EA09 18500D000000056 2417B01FFFFFFC1
// Both words WEX
1 0000F4002022F403 00003F000000000 000000000000000
// Only word 1 WEX stays scalar
1 0000F40000001234 103004000000034 004100000000000
// Dual-lane pairing, zero slot kept
1 000000005580F027 180315200000180 1C0355200000180
1 00000000AA23F030 40242A3FFFFFE23 44346A3FFFFFE23
// Pairing after a two-wide swap
1 5580F0272022F403 180315200000180 1C0355200000180
// Both words Df with srWxe off
0 0000F4002022F403 0C2048000000022 0030C0000000000

// File: wexDecoder.f
+incdir+.
hdl/bundleFmtPkg.sv
hdl/laneOpPkg.sv
hdl/bundleClassify.sv
hdl/opFieldDecode.sv
hdl/laneSteer.sv
hdl/wexDecoder.sv
bench/wexDecoderTb.sv
